// ==== tx_defines.svh ====
`ifndef TX_DEFINES_SVH
`define TX_DEFINES_SVH

// 64-bit datapath, one strobe per byte
`define TX_DATA_WIDTH   64
`define TX_STRB_WIDTH   8
`define TX_REM_WIDTH    1

`define TX_BUF_AV_WIDTH 6 // free transmit buffer count reported by the core

// a new packet needs at least this many free buffers
`define TX_START_THRESH 2

`endif

// ==== tx_axis_pkg.sv ====
`include "tx_defines.svh"

package tx_axis_pkg;

  localparam int TUSER_WIDTH = 4;
  localparam int DWORD_WIDTH = 32; // the beat holds two dwords

  typedef logic [`TX_DATA_WIDTH-1:0] tx_data_t;
  typedef logic [`TX_STRB_WIDTH-1:0] tx_strb_t;

  typedef struct packed {
    logic src_dsc;  // discontinue the packet at the source
    logic str;      // streamed packet
    logic errfwd;   // poisoned packet
    logic ecrc_gen; // core appends the ECRC
  } tx_tuser_flags_t;

  typedef union packed {
    logic [TUSER_WIDTH-1:0] raw;
    tx_tuser_flags_t        flags;
  } tx_tuser_u;

endpackage

// ==== tx_trn_pkg.sv ====
`include "tx_defines.svh"

package tx_trn_pkg;

  // 1 means both dwords of the beat carry data
  typedef logic [`TX_REM_WIDTH-1:0] trn_rem_t;

  // IDLE waits for enough buffers, PKT passes beats,
  // DRAIN accepts the rest of a packet after the link went down
  typedef enum logic [1:0] {
    IDLE,
    PKT,
    DRAIN
  } thrtl_state_e;

endpackage

// ==== axis_tx_if.sv ====
`timescale 1ns/1ps

interface axis_tx_if;
  import tx_axis_pkg::*;

  tx_data_t  tdata;
  logic      tvalid;
  tx_strb_t  tstrb;
  logic      tlast;
  tx_tuser_u tuser;
  logic      tready;
  logic      in_packet; // throttle is between the first beat and tlast

  modport ctl (
    input  tvalid,
    input  tlast,
    output tready,
    output in_packet
  );

  modport pipe (
    input tdata,
    input tvalid,
    input tstrb,
    input tlast,
    input tuser,
    input tready,
    input in_packet
  );

endinterface

// ==== tx_throttle_ctl.sv ====
`timescale 1ns/1ps
`include "tx_defines.svh"

module tx_throttle_ctl (
  axis_tx_if.ctl                      axis,
  input  logic [`TX_BUF_AV_WIDTH-1:0] trn_tbuf_av,
  input  logic                        trn_tdst_rdy,
  input  logic                        trn_lnk_up,
  input  logic                        user_clk,
  input  logic                        user_rst
);
  import tx_trn_pkg::*;

  thrtl_state_e state;
  thrtl_state_e state_nxt;
  logic         tready_q;
  logic         beat;
  logic         last_beat;
  logic         can_start;

  assign beat      = axis.tvalid && tready_q;
  assign last_beat = beat && axis.tlast;
  assign can_start = trn_lnk_up && trn_tdst_rdy &&
                     (trn_tbuf_av >= `TX_BUF_AV_WIDTH'(`TX_START_THRESH));

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (beat && !axis.tlast) begin
          state_nxt = trn_lnk_up ? PKT : DRAIN; // single-beat packets stay in IDLE
        end
      end
      PKT: begin
        if (last_beat) begin
          state_nxt = IDLE;
        end else if (!trn_lnk_up) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        if (last_beat) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      state    <= IDLE;
      tready_q <= 1'b0;
    end else begin
      state    <= state_nxt;
      tready_q <= (state_nxt != IDLE) || can_start; // re-evaluated after every tlast
    end
  end

  assign axis.tready    = tready_q;
  assign axis.in_packet = (state != IDLE);

  // a packet may only open on conditions seen with the link up
  tready_needs_link: assert property (
    @(posedge user_clk) disable iff (user_rst)
    (state == IDLE) && tready_q |-> $past(trn_lnk_up)
  ) else $error("tready high in IDLE although the link was down");

endmodule

// ==== tx_axi_pipeline.sv ====
`timescale 1ns/1ps
`include "tx_defines.svh"

module tx_axi_pipeline (
  axis_tx_if.pipe                    axis,
  input  logic                       trn_lnk_up,
  output logic [`TX_DATA_WIDTH-1:0]  trn_td,
  output logic                       trn_tsof,
  output logic                       trn_teof,
  output logic                       trn_tsrc_rdy,
  output tx_trn_pkg::trn_rem_t       trn_trem,
  output logic                       trn_terrfwd,
  output logic                       trn_tstr,
  output logic                       trn_tecrc_gen,
  output logic                       trn_tsrc_dsc,
  input  logic                       user_clk,
  input  logic                       user_rst
);
  import tx_axis_pkg::*;
  import tx_trn_pkg::*;

  tx_data_t  data_q;
  tx_strb_t  strb_q;
  logic      last_q;
  tx_tuser_u tuser_q;
  logic      src_rdy_q;
  logic      trn_in_q;
  logic      flush_q;
  logic      beat;
  logic      last_beat;
  logic      disable_trn;

  assign beat        = axis.tvalid && axis.tready;
  assign last_beat   = beat && axis.tlast;
  assign disable_trn = flush_q || !trn_lnk_up;

  always_ff @(posedge user_clk) begin
    if (beat) begin
      data_q <= axis.tdata;
      strb_q <= axis.tstrb;
      last_q <= axis.tlast;
    end
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      tuser_q.raw <= '0;
      src_rdy_q   <= 1'b0;
    end else begin
      if (beat) begin
        tuser_q.raw <= axis.tuser.raw;
      end
      src_rdy_q <= beat && !disable_trn; // flushed beats are registered but not shown
    end
  end

  // once the link drops inside a packet, nothing more of it reaches the core
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      flush_q <= 1'b0;
    end else if (last_beat) begin
      flush_q <= 1'b0;
    end else if ((axis.in_packet || beat) && !trn_lnk_up) begin
      flush_q <= 1'b1;
    end
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      trn_in_q <= 1'b0;
    end else if (trn_tsof && !trn_teof) begin
      trn_in_q <= 1'b1;
    end else if (trn_teof || !trn_lnk_up) begin
      trn_in_q <= 1'b0; // link loss closes the packet on the TRN side
    end
  end

  assign trn_tsrc_rdy = src_rdy_q && trn_lnk_up;
  assign trn_tsof     = trn_tsrc_rdy && !trn_in_q;
  assign trn_teof     = trn_tsrc_rdy && last_q;

  // TRN wants the lower AXI dword in the upper half
  assign trn_td   = {data_q[DWORD_WIDTH-1:0], data_q[2*DWORD_WIDTH-1:DWORD_WIDTH]};
  assign trn_trem = trn_rem_t'(strb_q[7]);

  assign trn_terrfwd   = tuser_q.flags.errfwd;
  assign trn_tstr      = tuser_q.flags.str;
  assign trn_tecrc_gen = tuser_q.flags.ecrc_gen;
  assign trn_tsrc_dsc  = tuser_q.flags.src_dsc;

  src_rdy_after_link: assert property (
    @(posedge user_clk) disable iff (user_rst)
    trn_tsrc_rdy |-> $past(trn_lnk_up)
  ) else $error("beat presented after link loss, throttle should be in state %0d", DRAIN);

  single_sof: assert property (
    @(posedge user_clk) disable iff (user_rst)
    trn_tsof && !trn_teof |=> !trn_tsof
  ) else $error("second tsof inside an open TRN packet");

endmodule

// ==== tx_bridge_top.sv ====
`timescale 1ns/1ps
`include "tx_defines.svh"

module tx_bridge_top (
  input  logic [`TX_DATA_WIDTH-1:0]           s_axis_tx_tdata,
  input  logic                                s_axis_tx_tvalid,
  input  tx_axis_pkg::tx_strb_t               s_axis_tx_tstrb,
  input  logic                                s_axis_tx_tlast,
  input  logic [tx_axis_pkg::TUSER_WIDTH-1:0] s_axis_tx_tuser,
  output logic                                s_axis_tx_tready,
  output logic [`TX_DATA_WIDTH-1:0]           trn_td,
  output logic                                trn_tsof,
  output logic                                trn_teof,
  output logic                                trn_tsrc_rdy,
  output tx_trn_pkg::trn_rem_t                trn_trem,
  output logic                                trn_terrfwd,
  output logic                                trn_tstr,
  output logic                                trn_tecrc_gen,
  output logic                                trn_tsrc_dsc,
  input  logic                                trn_tdst_rdy,
  input  logic                                trn_lnk_up,
  input  logic [`TX_BUF_AV_WIDTH-1:0]         trn_tbuf_av,
  input  logic                                user_clk,
  input  logic                                user_rst
);

  axis_tx_if axis ();

  assign axis.tdata     = s_axis_tx_tdata;
  assign axis.tvalid    = s_axis_tx_tvalid;
  assign axis.tstrb     = s_axis_tx_tstrb;
  assign axis.tlast     = s_axis_tx_tlast;
  assign axis.tuser.raw = s_axis_tx_tuser;
  assign s_axis_tx_tready = axis.tready;

  tx_throttle_ctl i_tx_throttle_ctl (
    .axis         (axis),
    .trn_tbuf_av  (trn_tbuf_av),
    .trn_tdst_rdy (trn_tdst_rdy),
    .trn_lnk_up   (trn_lnk_up),
    .user_clk     (user_clk),
    .user_rst     (user_rst)
  );

  tx_axi_pipeline i_tx_axi_pipeline (
    .axis          (axis),
    .trn_lnk_up    (trn_lnk_up),
    .trn_td        (trn_td),
    .trn_tsof      (trn_tsof),
    .trn_teof      (trn_teof),
    .trn_tsrc_rdy  (trn_tsrc_rdy),
    .trn_trem      (trn_trem),
    .trn_terrfwd   (trn_terrfwd),
    .trn_tstr      (trn_tstr),
    .trn_tecrc_gen (trn_tecrc_gen),
    .trn_tsrc_dsc  (trn_tsrc_dsc),
    .user_clk      (user_clk),
    .user_rst      (user_rst)
  );

endmodule

// ==== tb_tx_bridge.sv ====
`timescale 1ns/1ps
`include "tx_defines.svh"

module tb_tx_bridge;

  localparam int TIMEOUT_CYCLES = 2000; // about four times the length of all tests

  logic                        user_clk;
  logic                        user_rst;
  logic [`TX_DATA_WIDTH-1:0]   s_axis_tx_tdata;
  logic                        s_axis_tx_tvalid;
  logic [`TX_STRB_WIDTH-1:0]   s_axis_tx_tstrb;
  logic                        s_axis_tx_tlast;
  logic [3:0]                  s_axis_tx_tuser;
  logic                        s_axis_tx_tready;
  logic [`TX_DATA_WIDTH-1:0]   trn_td;
  logic                        trn_tsof;
  logic                        trn_teof;
  logic                        trn_tsrc_rdy;
  logic [`TX_REM_WIDTH-1:0]    trn_trem;
  logic                        trn_terrfwd;
  logic                        trn_tstr;
  logic                        trn_tecrc_gen;
  logic                        trn_tsrc_dsc;
  logic                        trn_tdst_rdy;
  logic                        trn_lnk_up;
  logic [`TX_BUF_AV_WIDTH-1:0] trn_tbuf_av;

  string       test_name = "reset";
  int          cycle = 0;
  int          sof_count = 0;
  int          stall_cycles;
  logic        in_pkt;   // axi side between first beat and tlast
  logic        flushing; // rest of the packet is dropped
  logic        trn_open; // a presented packet still waits for its teof
  logic [63:0] exp_td[$];
  logic [6:0]  exp_ctl[$]; // sof, eof, rem, src_dsc, str, errfwd, ecrc_gen
  int          exp_cyc[$];

  tx_bridge_top i_tx_bridge_top (.*);

  initial begin
    user_clk = 1'b0;
    forever #20 user_clk = ~user_clk;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_with_error($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  always @(posedge user_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("timeout in %s, the DUT stopped handshaking", test_name));
    end
  end

  // a beat accepted at the next edge is expected on TRN one cycle later unless flushed
  task automatic record_beat();
    if (trn_lnk_up && !flushing) begin
      exp_td.push_back({s_axis_tx_tdata[31:0], s_axis_tx_tdata[63:32]});
      exp_ctl.push_back({!trn_open, s_axis_tx_tlast,
                         s_axis_tx_tstrb[`TX_STRB_WIDTH-1], s_axis_tx_tuser});
      exp_cyc.push_back(cycle);
      trn_open = !s_axis_tx_tlast;
    end
    if (s_axis_tx_tlast) begin
      flushing = 1'b0;
    end else if (!trn_lnk_up) begin
      flushing = 1'b1;
    end
    in_pkt = !s_axis_tx_tlast;
  endtask

  always @(negedge user_clk) begin
    if (user_rst) begin
      in_pkt   = 1'b0;
      flushing = 1'b0;
      trn_open = 1'b0;
    end else begin
      if (trn_tsrc_rdy) begin
        if (exp_td.size() == 0) begin
          stop_with_error($sformatf("%s: TRN shows a beat that was never expected", test_name));
        end else begin
          check_value({test_name, " latency"}, 64'(exp_cyc.pop_front() + 1), 64'(cycle));
          check_value({test_name, " td"}, exp_td.pop_front(), trn_td);
          check_value({test_name, " ctl"}, 64'(exp_ctl.pop_front()),
                      64'({trn_tsof, trn_teof, trn_trem, trn_tsrc_dsc, trn_tstr,
                           trn_terrfwd, trn_tecrc_gen}));
          if (trn_tsof) sof_count++;
        end
      end
      if (s_axis_tx_tvalid && s_axis_tx_tready) begin
        record_beat();
      end else if (in_pkt && !trn_lnk_up) begin
        flushing = 1'b1;
      end
      if (!trn_lnk_up) trn_open = 1'b0; // link loss closes the TRN packet
    end
  end

  // called on a rising edge, returns on the edge that accepts the beat
  task automatic drive_beat(input logic [63:0] data, input logic [7:0] strb,
                            input logic last, input logic [3:0] tuser);
    logic accepted;
    s_axis_tx_tdata  <= data;
    s_axis_tx_tstrb  <= strb;
    s_axis_tx_tlast  <= last;
    s_axis_tx_tuser  <= tuser;
    s_axis_tx_tvalid <= 1'b1;
    accepted = 1'b0;
    stall_cycles = 0;
    while (!accepted) begin
      @(negedge user_clk);
      accepted = s_axis_tx_tready;
      if (!accepted) stall_cycles++;
      @(posedge user_clk);
    end
  endtask

  task automatic idle(input int n);
    s_axis_tx_tvalid <= 1'b0;
    repeat (n) @(posedge user_clk);
  endtask

  task automatic send_packet(input int len, input logic [3:0] tuser, input int max_gap);
    logic [7:0] strb;
    int         gap;
    for (int i = 0; i < len; i++) begin
      strb = (i == len - 1 && $urandom_range(1, 0) == 1) ? 8'h0F : 8'hFF;
      drive_beat({$urandom, $urandom}, strb, i == len - 1, tuser);
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      if (gap > 0) idle(gap);
    end
  endtask

  task automatic wait_drained();
    s_axis_tx_tvalid <= 1'b0;
    while (exp_td.size() != 0) @(posedge user_clk);
    repeat (2) @(posedge user_clk); // room for a stray beat to show up
  endtask

  task automatic single_packet();
    int start;
    test_name = "single_packet";
    start = sof_count;
    send_packet(3, 4'h0, 0);
    wait_drained();
    check_value("single_packet tsof count", 64'd1, 64'(sof_count - start));
  endtask

  task automatic tuser_flags();
    logic [3:0] values[4] = '{4'b1010, 4'b0101, 4'b1111, 4'b0011};
    test_name = "tuser_flags";
    foreach (values[i]) send_packet(2, values[i], 0);
    wait_drained();
  endtask

  task automatic buffer_throttle();
    logic [63:0] first;
    int          start;
    test_name = "buffer_throttle";
    start = sof_count;
    first = {$urandom, $urandom};
    trn_tbuf_av <= `TX_BUF_AV_WIDTH'(`TX_START_THRESH - 1);
    repeat (2) @(posedge user_clk);
    s_axis_tx_tdata  <= first;
    s_axis_tx_tstrb  <= 8'hFF;
    s_axis_tx_tlast  <= 1'b0;
    s_axis_tx_tuser  <= 4'h2;
    s_axis_tx_tvalid <= 1'b1;
    repeat (20) begin
      @(negedge user_clk);
      check_value("buffer_throttle tready", 64'd0, 64'(s_axis_tx_tready));
      check_value("buffer_throttle tsrc_rdy", 64'd0, 64'(trn_tsrc_rdy));
      @(posedge user_clk);
    end
    trn_tbuf_av <= `TX_BUF_AV_WIDTH'(`TX_START_THRESH);
    drive_beat(first, 8'hFF, 1'b0, 4'h2);
    drive_beat({$urandom, $urandom}, 8'hFF, 1'b0, 4'h2);
    drive_beat({$urandom, $urandom}, 8'h0F, 1'b1, 4'h2);
    wait_drained();
    check_value("buffer_throttle tsof count", 64'd1, 64'(sof_count - start));
  endtask

  task automatic link_drop_flush();
    int start;
    test_name = "link_drop_flush";
    start = sof_count;
    drive_beat({$urandom, $urandom}, 8'hFF, 1'b0, 4'h1);
    wait_drained();
    trn_lnk_up <= 1'b0;
    repeat (2) @(posedge user_clk);
    for (int i = 1; i < 4; i++) begin
      if (i == 2) trn_lnk_up <= 1'b1; // the link is back but the packet stays flushed
      drive_beat({$urandom, $urandom}, 8'hFF, i == 3, 4'h1);
      check_value("link_drop_flush tready stalls", 64'd0, 64'(stall_cycles));
    end
    s_axis_tx_tvalid <= 1'b0;
    @(negedge user_clk);
    check_value("link_drop_flush tready after tlast", 64'd1, 64'(s_axis_tx_tready));
    @(posedge user_clk);
    check_value("link_drop_flush tsof count", 64'd1, 64'(sof_count - start));
    send_packet(2, 4'h0, 0);
    wait_drained();
    check_value("link_drop_flush tsof after link up", 64'd2, 64'(sof_count - start));
  endtask

  task automatic random_stream();
    int start;
    int len;
    test_name = "random_stream";
    start = sof_count;
    repeat (10) begin
      len = int'($urandom_range(6, 1));
      send_packet(len, 4'($urandom), 2);
    end
    wait_drained();
    check_value("random_stream tsof count", 64'd10, 64'(sof_count - start));
  endtask

  initial begin
    void'($urandom(51407));
    user_rst         <= 1'b1;
    s_axis_tx_tdata  <= '0;
    s_axis_tx_tvalid <= 1'b0;
    s_axis_tx_tstrb  <= '0;
    s_axis_tx_tlast  <= 1'b0;
    s_axis_tx_tuser  <= '0;
    trn_tdst_rdy     <= 1'b1;
    trn_lnk_up       <= 1'b1;
    trn_tbuf_av      <= `TX_BUF_AV_WIDTH'(8);
    repeat (3) @(posedge user_clk);
    user_rst <= 1'b0;
    single_packet();
    tuser_flags();
    buffer_throttle();
    link_drop_flush();
    random_stream();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
tx_axis_pkg.sv
tx_trn_pkg.sv
axis_tx_if.sv
tx_throttle_ctl.sv
tx_axi_pipeline.sv
tx_bridge_top.sv
tb_tx_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and decide on the log contents

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module tb_tx_bridge -Mdir obj_dir -o sim_tb_tx_bridge
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_tb_tx_bridge > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
